// ==== verilog/rx_pkg.sv ====
// Receiver decimation definitions
`default_nettype none

package rx_pkg;

  // --------------------
  // Sample widths
  localparam int MIX_W   = 18;
  localparam int STAGE_W = 16;
  localparam int OUT_W   = 24;

  typedef logic signed [MIX_W-1:0]   mix_sample_t;
  typedef logic signed [STAGE_W-1:0] stage_sample_t;
  typedef logic signed [OUT_W-1:0]   out_sample_t;

  // Variable CIC rate codes, held from reset
  typedef logic [1:0] rate_sel_t;
  localparam rate_sel_t RATE_2  = 2'd0;
  localparam rate_sel_t RATE_4  = 2'd1;
  localparam rate_sel_t RATE_8  = 2'd2;
  localparam rate_sel_t RATE_16 = 2'd3;

  // --------------------
  // Fixed CIC, gain 4^3 = 64
  localparam int CIC_RATE   = 4;
  localparam int CIC_STAGES = 3;
  localparam int CIC_ACC_W  = MIX_W + CIC_STAGES * $clog2(CIC_RATE);
  typedef logic signed [CIC_ACC_W-1:0] cic_acc_t;
  typedef logic [$clog2(CIC_RATE)-1:0] cic_cnt_t;
  localparam cic_cnt_t CIC_CNT_LAST = cic_cnt_t'(CIC_RATE - 1);

  // Variable CIC, growth sized for the highest rate
  localparam int VARCIC_STAGES   = 5;
  localparam int VARCIC_MAX_RATE = 16;
  localparam int VARCIC_ACC_W    = STAGE_W + VARCIC_STAGES * $clog2(VARCIC_MAX_RATE);
  typedef logic signed [VARCIC_ACC_W-1:0]     varcic_acc_t;
  typedef logic [$clog2(VARCIC_MAX_RATE)-1:0] varcic_cnt_t;
  typedef logic [$clog2(VARCIC_ACC_W)-1:0]    varcic_shift_t;

  // --------------------
  // FIR, coefficients sum to 2^FIR_SHIFT
  localparam int FIR_TAPS  = 8;
  localparam int FIR_SHIFT = 6;
  localparam int FIR_ACC_W = 30;
  typedef logic signed [7:0]           coef_t;
  typedef logic signed [FIR_ACC_W-1:0] fir_acc_t;
  typedef logic [$clog2(FIR_TAPS)-1:0] fir_tap_t;
  localparam fir_tap_t FIR_TAP_LAST = fir_tap_t'(FIR_TAPS - 1);
  localparam coef_t FIR_COEF [FIR_TAPS] = '{
    8'sd1, 8'sd3, 8'sd8, 8'sd20, 8'sd20, 8'sd8, 8'sd3, 8'sd1
  };

  // FIR sequencer states
  typedef enum logic [1:0] {IDLE, MAC, DONE} fir_state_t;

endpackage

`default_nettype wire

// ==== verilog/cic_decim.sv ====
// Fixed rate CIC decimator
`default_nettype none

module cic_decim (
  input  wire                         clock,
  input  wire                         rst_n,
  input  wire rx_pkg::mix_sample_t    mix_i,
  input  wire rx_pkg::mix_sample_t    mix_q,
  output logic                        cic_strobe,
  output rx_pkg::stage_sample_t       cic_i,
  output rx_pkg::stage_sample_t       cic_q
);

  // Channel 0 carries I, channel 1 carries Q
  rx_pkg::mix_sample_t din   [2];
  rx_pkg::cic_acc_t    integ [2][rx_pkg::CIC_STAGES];
  rx_pkg::cic_acc_t    dly   [2][rx_pkg::CIC_STAGES];
  rx_pkg::cic_acc_t    diff  [2][rx_pkg::CIC_STAGES+1];
  rx_pkg::cic_cnt_t    cnt;
  logic                tick;

  assign din[0] = mix_i;
  assign din[1] = mix_q;

  // Last input of each group of four
  assign tick = (cnt == rx_pkg::CIC_CNT_LAST);

  // --------------------
  // Integrators, every clock
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cnt <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        for (int s = 0; s < rx_pkg::CIC_STAGES; s++) begin
          integ[ch][s] <= '0;
        end
      end
    end else begin
      cnt <= tick ? '0 : cnt + 1'b1;
      for (int ch = 0; ch < 2; ch++) begin
        // Input sign extended into the accumulator
        integ[ch][0] <= integ[ch][0] + rx_pkg::cic_acc_t'(din[ch]);
        for (int s = 1; s < rx_pkg::CIC_STAGES; s++) begin
          integ[ch][s] <= integ[ch][s] + integ[ch][s-1];
        end
      end
    end
  end

  // --------------------
  // Comb differences against the previous tick
  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      diff[ch][0] = integ[ch][rx_pkg::CIC_STAGES-1];
      for (int s = 0; s < rx_pkg::CIC_STAGES; s++) begin
        diff[ch][s+1] = diff[ch][s] - dly[ch][s];
      end
    end
  end

  // Comb delays and output on the decimation tick
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cic_strobe <= 1'b0;
      cic_i      <= '0;
      cic_q      <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        for (int s = 0; s < rx_pkg::CIC_STAGES; s++) begin
          dly[ch][s] <= '0;
        end
      end
    end else begin
      cic_strobe <= tick;
      if (tick) begin
        for (int ch = 0; ch < 2; ch++) begin
          for (int s = 0; s < rx_pkg::CIC_STAGES; s++) begin
            dly[ch][s] <= diff[ch][s];
          end
        end
        // Top bits drop the gain of 64 and two more LSBs
        cic_i <= diff[0][rx_pkg::CIC_STAGES][rx_pkg::CIC_ACC_W-1 -: rx_pkg::STAGE_W];
        cic_q <= diff[1][rx_pkg::CIC_STAGES][rx_pkg::CIC_ACC_W-1 -: rx_pkg::STAGE_W];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/varcic_decim.sv ====
// Variable rate CIC decimator
`default_nettype none

module varcic_decim (
  input  wire                          clock,
  input  wire                          rst_n,
  input  wire rx_pkg::rate_sel_t       rate_sel,
  input  wire                          in_strobe,
  input  wire rx_pkg::stage_sample_t   in_i,
  input  wire rx_pkg::stage_sample_t   in_q,
  output logic                         var_strobe,
  output rx_pkg::stage_sample_t        var_i,
  output rx_pkg::stage_sample_t        var_q
);

  // Channel 0 carries I, channel 1 carries Q
  rx_pkg::stage_sample_t din    [2];
  rx_pkg::varcic_acc_t   integ  [2][rx_pkg::VARCIC_STAGES];
  rx_pkg::varcic_acc_t   dly    [2][rx_pkg::VARCIC_STAGES];
  rx_pkg::varcic_acc_t   diff   [2][rx_pkg::VARCIC_STAGES+1];
  rx_pkg::varcic_acc_t   scaled [2];
  rx_pkg::rate_sel_t     rate_q;
  rx_pkg::varcic_cnt_t   cnt;
  rx_pkg::varcic_cnt_t   last_cnt;
  rx_pkg::varcic_shift_t shift;
  logic                  tick;

  assign din[0] = in_i;
  assign din[1] = in_q;

  // Rate sampled only while in reset
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rate_q <= rate_sel;
    end
  end

  // --------------------
  // Wrap count and gain shift per rate
  // Gain is R^5, so the shift is 5 * log2(R)
  always_comb begin
    last_cnt = rx_pkg::varcic_cnt_t'(1);
    shift    = rx_pkg::varcic_shift_t'(rx_pkg::VARCIC_STAGES);
    case (rate_q)
      rx_pkg::RATE_2: begin
        last_cnt = rx_pkg::varcic_cnt_t'(1);
        shift    = rx_pkg::varcic_shift_t'(rx_pkg::VARCIC_STAGES);
      end
      rx_pkg::RATE_4: begin
        last_cnt = rx_pkg::varcic_cnt_t'(3);
        shift    = rx_pkg::varcic_shift_t'(rx_pkg::VARCIC_STAGES * 2);
      end
      rx_pkg::RATE_8: begin
        last_cnt = rx_pkg::varcic_cnt_t'(7);
        shift    = rx_pkg::varcic_shift_t'(rx_pkg::VARCIC_STAGES * 3);
      end
      rx_pkg::RATE_16: begin
        last_cnt = rx_pkg::varcic_cnt_t'(15);
        shift    = rx_pkg::varcic_shift_t'(rx_pkg::VARCIC_STAGES * 4);
      end
    endcase
  end

  // R-th input strobe of each group
  assign tick = in_strobe && (cnt == last_cnt);

  // --------------------
  // Integrators, advanced by in_strobe
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cnt <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        for (int s = 0; s < rx_pkg::VARCIC_STAGES; s++) begin
          integ[ch][s] <= '0;
        end
      end
    end else if (in_strobe) begin
      cnt <= tick ? '0 : cnt + 1'b1;
      for (int ch = 0; ch < 2; ch++) begin
        integ[ch][0] <= integ[ch][0] + rx_pkg::varcic_acc_t'(din[ch]);
        for (int s = 1; s < rx_pkg::VARCIC_STAGES; s++) begin
          integ[ch][s] <= integ[ch][s] + integ[ch][s-1];
        end
      end
    end
  end

  // Comb chain and gain removal
  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      diff[ch][0] = integ[ch][rx_pkg::VARCIC_STAGES-1];
      for (int s = 0; s < rx_pkg::VARCIC_STAGES; s++) begin
        diff[ch][s+1] = diff[ch][s] - dly[ch][s];
      end
      scaled[ch] = diff[ch][rx_pkg::VARCIC_STAGES] >>> shift;
    end
  end

  // --------------------
  // Comb delays and output on the wrap
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      var_strobe <= 1'b0;
      var_i      <= '0;
      var_q      <= '0;
      for (int ch = 0; ch < 2; ch++) begin
        for (int s = 0; s < rx_pkg::VARCIC_STAGES; s++) begin
          dly[ch][s] <= '0;
        end
      end
    end else begin
      var_strobe <= tick;
      if (tick) begin
        for (int ch = 0; ch < 2; ch++) begin
          for (int s = 0; s < rx_pkg::VARCIC_STAGES; s++) begin
            dly[ch][s] <= diff[ch][s];
          end
        end
        var_i <= scaled[0][rx_pkg::STAGE_W-1:0];
        var_q <= scaled[1][rx_pkg::STAGE_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fir_decim.sv ====
// Sequential FIR decimator by two
`default_nettype none

module fir_decim (
  input  wire                          clock,
  input  wire                          rst_n,
  input  wire                          in_strobe,
  input  wire rx_pkg::stage_sample_t   in_i,
  input  wire rx_pkg::stage_sample_t   in_q,
  output logic                         out_strobe,
  output rx_pkg::out_sample_t          out_i,
  output rx_pkg::out_sample_t          out_q
);

  // Channel 0 carries I, channel 1 carries Q
  rx_pkg::stage_sample_t din  [2];
  rx_pkg::stage_sample_t dl   [2][rx_pkg::FIR_TAPS];
  rx_pkg::fir_acc_t      acc  [2];
  rx_pkg::fir_acc_t      prod [2];
  rx_pkg::fir_acc_t      rnd  [2];
  rx_pkg::stage_sample_t res  [2];
  rx_pkg::fir_tap_t      tap;
  rx_pkg::fir_state_t    state;
  logic                  phase;

  assign din[0] = in_i;
  assign din[1] = in_q;

  // --------------------
  // Delay line, newest sample at index 0
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      phase <= 1'b0;
      for (int ch = 0; ch < 2; ch++) begin
        for (int k = 0; k < rx_pkg::FIR_TAPS; k++) begin
          dl[ch][k] <= '0;
        end
      end
    end else if (in_strobe) begin
      // Phase high marks the second strobe of a pair
      phase <= ~phase;
      for (int ch = 0; ch < 2; ch++) begin
        dl[ch][0] <= din[ch];
        for (int k = 1; k < rx_pkg::FIR_TAPS; k++) begin
          dl[ch][k] <= dl[ch][k-1];
        end
      end
    end
  end

  // --------------------
  // One multiplier per channel, tap picked by the sequencer
  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      prod[ch] = dl[ch][tap] * rx_pkg::FIR_COEF[tap];
      // Half LSB added before the divide by 64
      rnd[ch]  = acc[ch] + (rx_pkg::fir_acc_t'(1) <<< (rx_pkg::FIR_SHIFT - 1));
      res[ch]  = rx_pkg::stage_sample_t'(rnd[ch] >>> rx_pkg::FIR_SHIFT);
    end
  end

  // --------------------
  // Sequencer
  // Load on the strobe edge, eight MAC cycles, one output cycle
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state      <= rx_pkg::IDLE;
      tap        <= '0;
      acc[0]     <= '0;
      acc[1]     <= '0;
      out_strobe <= 1'b0;
      out_i      <= '0;
      out_q      <= '0;
    end else begin
      out_strobe <= 1'b0;
      case (state)
        rx_pkg::IDLE: begin
          // New sample enters the delay line on this same edge
          if (in_strobe && phase) begin
            state  <= rx_pkg::MAC;
            tap    <= '0;
            acc[0] <= '0;
            acc[1] <= '0;
          end
        end
        rx_pkg::MAC: begin
          acc[0] <= acc[0] + prod[0];
          acc[1] <= acc[1] + prod[1];
          tap    <= tap + 1'b1;
          if (tap == rx_pkg::FIR_TAP_LAST) begin
            state <= rx_pkg::DONE;
          end
        end
        rx_pkg::DONE: begin
          // 16-bit result placed in the top of the 24-bit output
          out_i      <= {res[0], {(rx_pkg::OUT_W - rx_pkg::STAGE_W){1'b0}}};
          out_q      <= {res[1], {(rx_pkg::OUT_W - rx_pkg::STAGE_W){1'b0}}};
          out_strobe <= 1'b1;
          state      <= rx_pkg::IDLE;
        end
        default: begin
          state <= rx_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/receiver_decim.sv ====
// Receiver decimation chain
`default_nettype none

module receiver_decim (
  input  wire                          clock,
  input  wire                          rst_n,
  input  wire rx_pkg::rate_sel_t       rate_sel,
  input  wire rx_pkg::mix_sample_t     mix_i,
  input  wire rx_pkg::mix_sample_t     mix_q,
  output logic                         out_strobe,
  output rx_pkg::out_sample_t          out_i,
  output rx_pkg::out_sample_t          out_q
);

  // --------------------
  // Stage to stage signals
  logic                  cic_strobe;
  rx_pkg::stage_sample_t cic_i;
  rx_pkg::stage_sample_t cic_q;

  logic                  var_strobe;
  rx_pkg::stage_sample_t var_i;
  rx_pkg::stage_sample_t var_q;

  // Fixed decimation by 4, input every clock
  // Output is the input with its two LSBs dropped
  cic_decim u_cic (
    .clock      (clock),
    .rst_n      (rst_n),
    .mix_i      (mix_i),
    .mix_q      (mix_q),
    .cic_strobe (cic_strobe),
    .cic_i      (cic_i),
    .cic_q      (cic_q)
  );

  // Decimation by 2, 4, 8 or 16, unity gain
  varcic_decim u_varcic (
    .clock      (clock),
    .rst_n      (rst_n),
    .rate_sel   (rate_sel),
    .in_strobe  (cic_strobe),
    .in_i       (cic_i),
    .in_q       (cic_q),
    .var_strobe (var_strobe),
    .var_i      (var_i),
    .var_q      (var_q)
  );

  // Final decimation by 2
  // Output strobe 10 clocks after every second var_strobe
  fir_decim u_fir (
    .clock      (clock),
    .rst_n      (rst_n),
    .in_strobe  (var_strobe),
    .in_i       (var_i),
    .in_q       (var_q),
    .out_strobe (out_strobe),
    .out_i      (out_i),
    .out_q      (out_q)
  );

endmodule

`default_nettype wire

// ==== test/receiver_decim_sva.sv ====
// Output strobe assertions
`default_nettype none

module receiver_decim_sva (
  input wire                      clock,
  input wire                      rst_n,
  input wire rx_pkg::rate_sel_t   rate_sel,
  input wire                      out_strobe,
  input wire rx_pkg::out_sample_t out_i,
  input wire rx_pkg::out_sample_t out_q
);

  rx_pkg::rate_sel_t rate_q;
  int                gap;
  int                since_last;
  logic              seen;
  // Number of failed assertions
  int                fail_count = 0;

  // --------------------
  // Output every 8R clocks at the rate held from reset
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rate_q <= rate_sel;
    end
  end

  always_comb gap = 8 * (2 << rate_q);

  // Clocks since reset release or the last strobe
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      since_last <= 0;
      seen       <= 1'b0;
    end else if (out_strobe) begin
      since_last <= 1;
      seen       <= 1'b1;
    end else begin
      since_last <= since_last + 1;
    end
  end

  // --------------------
  a_quiet_in_reset: assert property (@(posedge clock) !rst_n |=> !out_strobe)
    else begin
      $error("out_strobe high during reset");
      fail_count++;
    end

  a_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
    out_strobe |=> !out_strobe)
    else begin
      $error("out_strobe longer than one cycle");
      fail_count++;
    end

  a_held_between: assert property (@(posedge clock) disable iff (!rst_n)
    !out_strobe |-> ($stable(out_i) && $stable(out_q)))
    else begin
      $error("output data changed between strobes");
      fail_count++;
    end

  // First output only after the chain has filled
  a_first_late: assert property (@(posedge clock) disable iff (!rst_n)
    (out_strobe && !seen) |-> (since_last > gap))
    else begin
      $error("first out_strobe too early after reset");
      fail_count++;
    end

  a_exact_gap: assert property (@(posedge clock) disable iff (!rst_n)
    (out_strobe && seen) |-> (since_last == gap))
    else begin
      $error("out_strobe spacing differs from 8R");
      fail_count++;
    end

  a_not_missing: assert property (@(posedge clock) disable iff (!rst_n)
    seen |-> (since_last <= gap))
    else begin
      $error("out_strobe missing after 8R clocks");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== test/tb_receiver_decim.sv ====
// Receiver decimation chain testbench
`default_nettype none

module tb_receiver_decim;

  // --------------------
  // DUT signals
  logic                clock;
  logic                rst_n;
  rx_pkg::rate_sel_t   rate_sel;
  rx_pkg::mix_sample_t mix_i;
  rx_pkg::mix_sample_t mix_q;
  logic                out_strobe;
  rx_pkg::out_sample_t out_i;
  rx_pkg::out_sample_t out_q;

  // Stimulus levels applied every clock by the driver
  rx_pkg::mix_sample_t stim_i;
  rx_pkg::mix_sample_t stim_q;
  logic                alt_mode;
  logic                alt_flip;

  // Run bookkeeping
  int   errors;
  int   seed;
  int   exp_gap;
  int   strobe_limit;
  logic have_prev;
  logic timed_out;

  receiver_decim UUT (
    .clock      (clock),
    .rst_n      (rst_n),
    .rate_sel   (rate_sel),
    .mix_i      (mix_i),
    .mix_q      (mix_q),
    .out_strobe (out_strobe),
    .out_i      (out_i),
    .out_q      (out_q)
  );

  // Concurrent checks on the top level
  bind receiver_decim receiver_decim_sva u_sva (
    .clock      (clock),
    .rst_n      (rst_n),
    .rate_sel   (rate_sel),
    .out_strobe (out_strobe),
    .out_i      (out_i),
    .out_q      (out_q)
  );

  always #5 clock = ~clock;

  // --------------------
  // Input driver on the falling edge
  // Alternate mode flips the sign on every clock
  always @(negedge clock) begin
    alt_flip = ~alt_flip;
    if (alt_mode && alt_flip) begin
      mix_i = -stim_i;
      mix_q = -stim_q;
    end else begin
      mix_i = stim_i;
      mix_q = stim_q;
    end
  end

  // Settled DC output drops two LSBs in the first CIC and gains eight bits at the FIR
  function automatic rx_pkg::out_sample_t dc_expect(input rx_pkg::mix_sample_t x);
    rx_pkg::out_sample_t narrowed;
    narrowed = rx_pkg::out_sample_t'(x >>> 2);
    return narrowed <<< 8;
  endfunction

  task automatic check_value(input string name, input rx_pkg::out_sample_t exp,
                             input rx_pkg::out_sample_t got);
    assert (got === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, got);
      errors++;
    end
  endtask

  // --------------------
  // Wait for the next output strobe
  // Gap counted in clocks from the previous strobe
  task automatic next_strobe();
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!out_strobe && waited < strobe_limit);
    if (!out_strobe) begin
      $display("Timeout: no output strobe arrived within %0d clocks", strobe_limit);
      errors++;
      timed_out = 1'b1;
    end else begin
      // First strobe after reset has no reference point
      if (have_prev) begin
        assert (waited == exp_gap) else begin
          $display("[FAIL] out_strobe spacing expected %h actual %h", exp_gap, waited);
          errors++;
        end
      end
      have_prev = 1'b1;
    end
  endtask

  task automatic settle(input int count);
    for (int n = 0; n < count && !timed_out; n++) begin
      next_strobe();
    end
  endtask

  // Three clocks of reset with the rate held from here on
  task automatic apply_reset(input rx_pkg::rate_sel_t code);
    @(negedge clock);
    rst_n    = 1'b0;
    rate_sel = code;
    repeat (3) @(negedge clock);
    rst_n     = 1'b1;
    have_prev = 1'b0;
  endtask

  // --------------------
  // One reset run per rate code
  task automatic run_rate(input rx_pkg::rate_sel_t code);
    rx_pkg::mix_sample_t x;
    rx_pkg::mix_sample_t y;
    rx_pkg::mix_sample_t amp;
    // One output every 8R clocks with R = 2 << code
    exp_gap      = 8 * (2 << code);
    strobe_limit = 2 * exp_gap + 64;

    // Random DC levels that differ between I and Q
    x = rx_pkg::mix_sample_t'($random(seed));
    y = rx_pkg::mix_sample_t'($random(seed));
    if (y == x) begin
      y = ~x;
    end
    stim_i   = x;
    stim_q   = y;
    alt_mode = 1'b0;
    apply_reset(code);
    settle(20);
    if (!timed_out) begin
      check_value("out_i", dc_expect(x), out_i);
      check_value("out_q", dc_expect(y), out_q);
    end

    // Most negative full scale on I and most positive on Q
    stim_i = 18'sh20000;
    stim_q = 18'sh1FFFF;
    settle(20);
    if (!timed_out) begin
      check_value("out_i", dc_expect(18'sh20000), out_i);
      check_value("out_q", dc_expect(18'sh1FFFF), out_q);
    end

    // Tone at half the input rate is nulled by the rate-4 CIC
    amp      = rx_pkg::mix_sample_t'(($random(seed) & 32'h7FFF) | 32'h0100);
    stim_i   = amp;
    stim_q   = -amp;
    alt_mode = 1'b1;
    settle(20);
    if (!timed_out) begin
      check_value("out_i", '0, out_i);
      check_value("out_q", '0, out_q);
    end
    alt_mode = 1'b0;
  endtask

  // --------------------
  // Main sequence
  initial begin
    clock        = 1'b0;
    rst_n        = 1'b0;
    rate_sel     = rx_pkg::RATE_2;
    mix_i        = '0;
    mix_q        = '0;
    stim_i       = '0;
    stim_q       = '0;
    alt_mode     = 1'b0;
    alt_flip     = 1'b0;
    errors       = 0;
    seed         = 32'h4826;
    exp_gap      = 0;
    strobe_limit = 0;
    have_prev    = 1'b0;
    timed_out    = 1'b0;

    for (int code = 0; code < 4; code++) begin
      if (!timed_out) begin
        run_rate(rx_pkg::rate_sel_t'(code));
      end
    end

    $display("Run finished with %0d check errors and %0d assertion errors",
             errors, UUT.u_sva.fail_count);
    if (errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/rx_pkg.sv
verilog/cic_decim.sv
verilog/varcic_decim.sv
verilog/fir_decim.sv
verilog/receiver_decim.sv
test/receiver_decim_sva.sv
test/tb_receiver_decim.sv

// ==== Bender.yml ====
package:
  name: receiver_decim

sources:
  - verilog/rx_pkg.sv
  - verilog/cic_decim.sv
  - verilog/varcic_decim.sv
  - verilog/fir_decim.sv
  - verilog/receiver_decim.sv
  - target: test
    files:
      - test/receiver_decim_sva.sv
      - test/tb_receiver_decim.sv
